/* build.f */
+incdir+include
source/dmem_pkg.sv
source/dmem_load_align.sv
source/dmem_amo_alu.sv
source/dmem_ctrl.sv
source/dmem_top.sv
tests/dmem_sva.sv
tests/dmem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module dmem_tb -o dmem_sim

if ./obj_dir/dmem_sim | tee /dev/stderr | grep -x 'PASS: all tests' > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tests/dmem_tb.sv */
`default_nettype none

`include "dmem_cfg.svh"

module dmem_tb;
    import dmem_pkg::*;

    localparam int LINES      = `DMEM_LINES;
    localparam int DELAY      = `DMEM_DELAY;
    localparam int N_LOADS    = 200;
    localparam int N_STORES   = 100;
    localparam int AMO_REPS   = 3;
    localparam int SC_ROUNDS  = 4;
    localparam int N_BURST    = 20;
    localparam int TOTAL_REQS = 2 * LINES + N_LOADS + 2 * N_STORES + 36 * AMO_REPS
                                + 8 * SC_ROUNDS + N_BURST;
    localparam int TIMEOUT    = TOTAL_REQS * (DELAY + 4) * 10 + 1000;

    logic         clk_i;
    logic         rstn_i;
    addr_t        addr_i;
    logic         valid_i;
    logic [7:0]   tag_i;
    mem_cmd_e     cmd_i;
    mem_size_e    size_i;
    logic [127:0] wr_data_i;
    logic [127:0] line_o;
    logic         ready_o;
    logic         valid_o;
    logic [7:0]   tag_o;

    logic [127:0] shadow [LINES];  // expected array contents
    logic         resv_valid;
    addr_t        resv_addr;
    logic [127:0] exp_line_q [$];
    logic [7:0]   exp_tag_q [$];
    bit           exp_chk_q [$];
    int           exp_time_q [$];  // acceptance edge
    int           outstanding;
    int           checks;
    int           errors;
    logic [7:0]   next_tag;
    int unsigned  seed_val;

    dmem_top dut0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .addr_i    (addr_i),
        .valid_i   (valid_i),
        .tag_i     (tag_i),
        .cmd_i     (cmd_i),
        .size_i    (size_i),
        .wr_data_i (wr_data_i),
        .line_o    (line_o),
        .ready_o   (ready_o),
        .valid_o   (valid_o),
        .tag_o     (tag_o)
    );

    bind dmem_ctrl dmem_sva u_sva (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .valid_o (valid_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic int size_bytes(input mem_size_e sz);
        case (sz)
            B, BU:   return 1;
            H, HU:   return 2;
            W, WU:   return 4;
            D, DU:   return 8;
            default: return 16;
        endcase
    endfunction

    function automatic logic [127:0] rand_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic addr_t rand_addr(input mem_size_e sz);
        int nb;
        nb = size_bytes(sz);
        return addr_t'((($urandom % LINES) << 4) | (($urandom % 16) & ~(nb - 1)));
    endfunction

    // word operands widened by sign before the operation
    function automatic logic [63:0] amo_value(input mem_cmd_e cmd, input mem_size_e sz,
                                              input logic [127:0] old,
                                              input logic [127:0] data);
        logic signed [63:0] a;
        logic signed [63:0] b;
        if (sz == D) begin
            a = old[63:0];
            b = data[63:0];
        end else begin
            a = 64'($signed(old[31:0]));
            b = 64'($signed(data[31:0]));
        end
        case (cmd)
            AMOADD:  return a + b;
            AMOXOR:  return a ^ b;
            AMOAND:  return a & b;
            AMOOR:   return a | b;
            AMOMIN:  return (a < b) ? a : b;
            AMOMAX:  return (a > b) ? a : b;
            AMOMINU: return ($unsigned(a) < $unsigned(b)) ? a : b;
            AMOMAXU: return ($unsigned(a) > $unsigned(b)) ? a : b;
            default: return b;
        endcase
    endfunction

    // expected response of one request, applies its write to the shadow array
    function automatic logic [127:0] dmem_ref(input mem_cmd_e cmd, input mem_size_e sz,
                                              input addr_t addr, input logic [127:0] data);
        int           idx;
        int           off;
        int           nb;
        logic [127:0] line;
        logic [127:0] mask;
        logic [127:0] old;
        logic [127:0] res;
        logic [127:0] wval;
        logic         write;
        logic         ok;
        idx  = int'(addr[31:4]) % LINES;
        off  = int'(addr[3:0]);
        nb   = size_bytes(sz);
        line = shadow[idx];
        mask = (nb == 16) ? {128{1'b1}} : ((128'd1 << (nb * 8)) - 128'd1);
        old  = (line >> (off * 8)) & mask;
        if (sz < BU && old[7'(nb * 8 - 1)]) begin
            old = old | ~mask;  // signed sizes
        end
        res   = old;
        wval  = data;
        write = 1'b1;
        if (cmd == LOAD) begin
            write = 1'b0;
        end else if (cmd == LR) begin
            write      = 1'b0;
            resv_valid = 1'b1;
            resv_addr  = addr;
        end else if (cmd == SC) begin
            ok         = resv_valid && (resv_addr == addr);
            res        = {127'b0, !ok};
            write      = ok;
            resv_valid = 1'b0;
        end else if (cmd != STORE && cmd != AMOSWAP) begin
            wval = {64'b0, amo_value(cmd, sz, old, data)};
        end
        if (write) begin
            shadow[idx] = (line & ~(mask << (off * 8))) | ((wval & mask) << (off * 8));
        end
        return res;
    endfunction

    // holds the request until accepted, store data follows one cycle later
    task automatic send_req(input mem_cmd_e cmd, input mem_size_e sz, input addr_t addr,
                            input logic [127:0] data, input bit chk, output int t_acc);
        bit taken;
        valid_i   = 1'b1;
        cmd_i     = cmd;
        size_i    = sz;
        addr_i    = addr;
        tag_i     = next_tag;
        wr_data_i = rand_line();  // junk until the data cycle
        taken     = 1'b0;
        while (!taken) begin
            taken = ready_o;  // stable until the next edge
            @(posedge clk_i);
            #1;
        end
        t_acc = int'($time) - 1;
        exp_line_q.push_back(dmem_ref(cmd, sz, addr, data));
        exp_tag_q.push_back(next_tag);
        exp_chk_q.push_back(chk);
        exp_time_q.push_back(t_acc);
        outstanding++;
        next_tag++;
        valid_i   = 1'b0;
        wr_data_i = data;
        @(posedge clk_i);
        #1;
    endtask

    task automatic end_test(input string name, input int start_err);
        wait (outstanding == 0);
        @(posedge clk_i);
        #1;
        $display("test %s done, %0d errors", name, errors - start_err);
    endtask

    initial begin : stimulus
        int        start_err;
        int        t_acc;
        int        t_prev;
        addr_t     a;
        mem_size_e sz;
        mem_cmd_e  amo_cmds [9];
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        addr_i      = '0;
        valid_i     = 1'b0;
        tag_i       = '0;
        cmd_i       = LOAD;
        size_i      = B;
        wr_data_i   = '0;
        resv_valid  = 1'b0;
        resv_addr   = '0;
        outstanding = 0;
        checks      = 0;
        errors      = 0;
        next_tag    = '0;
        seed_val    = $urandom(32'h1ece773b);
        amo_cmds    = '{AMOSWAP, AMOADD, AMOXOR, AMOAND, AMOOR,
                        AMOMIN, AMOMAX, AMOMINU, AMOMAXU};
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        start_err = errors;
        for (int i = 0; i < LINES; i++) begin
            send_req(STORE, LINE, addr_t'(i << 4), rand_line(), 1'b0, t_acc);
        end
        for (int i = 0; i < LINES; i++) begin
            send_req(LOAD, LINE, addr_t'(i << 4), '0, 1'b1, t_acc);
        end
        end_test("line_fill", start_err);

        start_err = errors;
        for (int i = 0; i < N_LOADS; i++) begin
            sz = mem_size_e'(4'($urandom % 8));
            send_req(LOAD, sz, rand_addr(sz), '0, 1'b1, t_acc);
        end
        end_test("sized_loads", start_err);

        start_err = errors;
        for (int i = 0; i < N_STORES; i++) begin
            sz = mem_size_e'(4'($urandom % 8));
            a  = rand_addr(sz);
            send_req(STORE, sz, a, rand_line(), 1'b1, t_acc);
            send_req(LOAD, LINE, a & ~32'hf, '0, 1'b1, t_acc);  // merged line
        end
        end_test("sized_stores", start_err);

        start_err = errors;
        foreach (amo_cmds[c]) begin
            for (int s = 0; s < 2; s++) begin
                if (s == 0) begin
                    sz = W;
                end else begin
                    sz = D;
                end
                for (int r = 0; r < AMO_REPS; r++) begin
                    a = rand_addr(sz);
                    send_req(amo_cmds[c], sz, a, rand_line(), 1'b1, t_acc);
                    send_req(LOAD, sz, a, '0, 1'b1, t_acc);
                end
            end
        end
        end_test("amo", start_err);

        start_err = errors;
        for (int i = 0; i < SC_ROUNDS; i++) begin
            a = rand_addr(D);
            send_req(SC, D, a, rand_line(), 1'b1, t_acc);          // no reservation
            send_req(LR, D, a, '0, 1'b1, t_acc);
            send_req(SC, D, a, rand_line(), 1'b1, t_acc);          // succeeds
            send_req(LOAD, D, a, '0, 1'b1, t_acc);
            send_req(SC, D, a, rand_line(), 1'b1, t_acc);          // already used
            send_req(LR, D, a, '0, 1'b1, t_acc);
            send_req(SC, D, a ^ 32'h8, rand_line(), 1'b1, t_acc);  // other address
            send_req(LOAD, D, a ^ 32'h8, '0, 1'b1, t_acc);
        end
        end_test("lr_sc", start_err);

        // each request is held while the previous one is busy
        start_err = errors;
        send_req(LOAD, LINE, rand_addr(LINE), '0, 1'b1, t_prev);
        for (int i = 1; i < N_BURST; i++) begin
            sz = mem_size_e'(4'($urandom % 8));
            send_req(LOAD, sz, rand_addr(sz), '0, 1'b1, t_acc);
            checks++;
            assert (t_acc == t_prev + (DELAY + 1) * 10) else begin
                $display("request accepted at %0t, expected at %0t when ready_o returned",
                         t_acc, t_prev + (DELAY + 1) * 10);
                errors++;
            end
            t_prev = t_acc;
        end
        end_test("timing", start_err);

        $display("tests run: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // outputs are stable at the falling edge
    initial begin : compare
        logic [127:0] e_line;
        logic [7:0]   e_tag;
        bit           e_chk;
        int           e_time;
        forever begin
            @(negedge clk_i);
            if (valid_o === 1'b1) begin
                checks++;
                assert (exp_tag_q.size() != 0) else begin
                    $display("response at %0t without a pending request", $time);
                    errors++;
                end
                if (exp_tag_q.size() != 0) begin
                    e_line = exp_line_q.pop_front();
                    e_tag  = exp_tag_q.pop_front();
                    e_chk  = exp_chk_q.pop_front();
                    e_time = exp_time_q.pop_front();
                    checks++;
                    assert (tag_o === e_tag) else begin
                        $display("[FAIL] t=%0t tag_o expected %h got %h", $time, e_tag, tag_o);
                        errors++;
                    end
                    if (e_chk) begin
                        checks++;
                        assert (line_o === e_line) else begin
                            $display("[FAIL] t=%0t line_o expected %h got %h",
                                     $time, e_line, line_o);
                            errors++;
                        end
                    end
                    checks++;
                    assert (int'($time) == e_time + (DELAY - 1) * 10 + 5) else begin
                        $display("response for tag %h arrived at %0t instead of %0t",
                                 e_tag, $time, e_time + (DELAY - 1) * 10 + 5);
                        errors++;
                    end
                    outstanding--;
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("the run hung, %0d responses still pending at %0t", outstanding, $time);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/dmem_sva.sv */
`default_nettype none

`include "dmem_cfg.svh"

module dmem_sva (
    input logic clk_i,
    input logic rstn_i,
    input logic valid_i,
    input logic ready_o,
    input logic valid_o
);
    localparam int DELAY = `DMEM_DELAY;

    logic accept;

    assign accept = valid_i && ready_o;

    a_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i) valid_o |=> !valid_o)
        else $error("valid_o held for more than one cycle");

    // ready_o stays low through the response and comes back right after it
    a_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
                             valid_o |-> !ready_o ##1 ready_o)
        else $error("ready_o not low with valid_o or not back in the next cycle");

    // quiet cycles between acceptance and the response
    for (genvar k = 1; k < DELAY; k++) begin : g_quiet
        a_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i) accept |-> ##k !valid_o)
            else $error("valid_o came %0d cycles after acceptance", k);
    end

    a_resp: assert property (@(posedge clk_i) disable iff (!rstn_i) accept |-> ##DELAY valid_o)
        else $error("no valid_o %0d cycles after acceptance", DELAY);

    a_reset: assert property (@(posedge clk_i) !rstn_i |-> !valid_o)
        else $error("valid_o high during reset");

endmodule

`default_nettype wire

/* source/dmem_top.sv */
`default_nettype none

module dmem_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  dmem_pkg::addr_t     addr_i,
    input  logic                valid_i,
    input  logic [7:0]          tag_i,
    input  dmem_pkg::mem_cmd_e  cmd_i,
    input  dmem_pkg::mem_size_e size_i,
    input  logic [127:0]        wr_data_i,
    output logic [127:0]        line_o,
    output logic                ready_o,
    output logic                valid_o,
    output logic [7:0]          tag_o
);
    import dmem_pkg::*;

    line_u        mem_line;    // raw line from the array
    line_u        elem;        // extended element
    logic [3:0]   offset;
    mem_size_e    align_size;
    mem_cmd_e     held_cmd;
    mem_size_e    held_size;
    logic [127:0] held_elem;
    logic [127:0] amo_result;

    dmem_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .addr_i       (addr_i),
        .valid_i      (valid_i),
        .tag_i        (tag_i),
        .cmd_i        (cmd_i),
        .size_i       (size_i),
        .wr_data_i    (wr_data_i),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .tag_o        (tag_o),
        .line_o       (line_o),
        .mem_line_o   (mem_line),
        .offset_o     (offset),
        .size_o       (align_size),
        .elem_i       (elem),
        .held_cmd_o   (held_cmd),
        .held_size_o  (held_size),
        .held_elem_o  (held_elem),
        .amo_result_i (amo_result)
    );

    dmem_load_align u_align (
        .line_i   (mem_line),
        .offset_i (offset),
        .size_i   (align_size),
        .elem_o   (elem)
    );

    // store data goes straight in, it is valid in the write cycle
    dmem_amo_alu u_alu (
        .cmd_i    (held_cmd),
        .size_i   (held_size),
        .old_i    (held_elem),
        .core_i   (wr_data_i),
        .result_o (amo_result)
    );

endmodule

`default_nettype wire

/* source/dmem_ctrl.sv */
`default_nettype none

`include "dmem_cfg.svh"

module dmem_ctrl (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  dmem_pkg::addr_t     addr_i,
    input  logic                valid_i,
    input  logic [7:0]          tag_i,
    input  dmem_pkg::mem_cmd_e  cmd_i,
    input  dmem_pkg::mem_size_e size_i,
    input  logic [127:0]        wr_data_i,
    output logic                ready_o,
    output logic                valid_o,
    output logic [7:0]          tag_o,
    output logic [127:0]        line_o,
    output dmem_pkg::line_u     mem_line_o,   // to the aligner
    output logic [3:0]          offset_o,
    output dmem_pkg::mem_size_e size_o,
    input  dmem_pkg::line_u     elem_i,
    output dmem_pkg::mem_cmd_e  held_cmd_o,   // to the alu
    output dmem_pkg::mem_size_e held_size_o,
    output logic [127:0]        held_elem_o,
    input  logic [127:0]        amo_result_i
);
    import dmem_pkg::*;

    localparam int unsigned LINES = `DMEM_LINES;
    localparam int unsigned DELAY = `DMEM_DELAY;
    localparam int unsigned IDX_W = $clog2(LINES);
    localparam int unsigned CNT_W = $clog2(DELAY + 1);

    typedef enum logic [1:0] {IDLE, STORE_WRITE, WAIT} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [7:0]       tag_q;
    logic [127:0]     line_q;     // response, also the old element
    mem_cmd_e         cmd_q;
    mem_size_e        size_q;
    addr_t            addr_q;
    logic             resv_valid_q;
    addr_t            resv_addr_q;

    line_u            mem_q [LINES];
    logic [IDX_W-1:0] idx_in;
    logic [IDX_W-1:0] idx_q;
    logic [IDX_W-1:0] rd_idx;
    logic             accept;
    logic             is_write;
    logic             sc_ok;
    logic             do_write;
    logic [15:0]      be_raw;
    logic [15:0]      be;
    line_u            wr_val;
    line_u            shifted;
    line_u            merged;

    assign idx_in = IDX_W'(addr_i[31:4] % LINES);
    assign idx_q  = IDX_W'(addr_q[31:4] % LINES);

    assign accept   = valid_i && ready_o;
    assign is_write = (cmd_i != LOAD) && (cmd_i != LR);
    assign sc_ok    = resv_valid_q && (resv_addr_q == addr_i);

    // counter at zero means idle, at one means response cycle
    assign ready_o = (cnt_q == '0);
    assign valid_o = (cnt_q == CNT_W'(1));
    assign tag_o   = tag_q;
    assign line_o  = line_q;

    // single read port, the write merge reuses it in STORE_WRITE
    assign rd_idx      = (state_q == STORE_WRITE) ? idx_q : idx_in;
    assign mem_line_o  = mem_q[rd_idx];
    assign offset_o    = addr_i[3:0];
    assign size_o      = size_i;
    assign held_cmd_o  = cmd_q;
    assign held_size_o = size_q;
    assign held_elem_o = line_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= IDLE;
            cnt_q        <= '0;
            tag_q        <= '0;
            line_q       <= '0;
            resv_valid_q <= 1'b0;
            resv_addr_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= is_write ? STORE_WRITE : WAIT;
                        cnt_q   <= CNT_W'(DELAY);
                        tag_q   <= tag_i;
                        if (cmd_i == SC) begin
                            line_q       <= {127'b0, !sc_ok};  // 0 on success
                            resv_valid_q <= 1'b0;
                        end else begin
                            line_q <= elem_i.flat;
                        end
                        if (cmd_i == LR) begin
                            resv_valid_q <= 1'b1;
                            resv_addr_q  <= addr_i;
                        end
                    end
                end
                STORE_WRITE: begin  // store data is on wr_data_i now
                    state_q <= WAIT;
                    cnt_q   <= cnt_q - CNT_W'(1);
                end
                default: begin
                    cnt_q <= cnt_q - CNT_W'(1);
                    if (cnt_q == CNT_W'(1)) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q  <= cmd_i;
            size_q <= size_i;
            addr_q <= addr_i;
        end
    end

    // bytes touched by the held access
    always_comb begin
        case (size_q)
            B, BU:   be_raw = 16'h0001;
            H, HU:   be_raw = 16'h0003;
            W, WU:   be_raw = 16'h000f;
            D, DU:   be_raw = 16'h00ff;
            default: be_raw = 16'hffff;
        endcase
    end

    assign be       = be_raw << addr_q[3:0];
    assign wr_val   = amo_result_i;
    assign shifted  = wr_val.flat << {addr_q[3:0], 3'b000};
    assign do_write = (cmd_q != SC) || !line_q[0];

    always_comb begin
        merged = mem_line_o;
        for (int i = 0; i < 16; i++) begin
            if (be[i]) begin
                merged.b[i] = shifted.b[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == STORE_WRITE && do_write) begin
            mem_q[idx_q] <= merged;
        end
    end

endmodule

`default_nettype wire

/* source/dmem_amo_alu.sv */
`default_nettype none

module dmem_amo_alu (
    input  dmem_pkg::mem_cmd_e  cmd_i,
    input  dmem_pkg::mem_size_e size_i,
    input  logic [127:0]        old_i,
    input  logic [127:0]        core_i,
    output logic [127:0]        result_o
);
    import dmem_pkg::*;

    line_u       old_v;
    line_u       core_v;
    line_u       res_v;
    logic        is_word;
    logic [63:0] op_a;
    logic [63:0] op_b;
    logic [63:0] amo_val;

    assign old_v   = old_i;
    assign core_v  = core_i;
    assign is_word = (size_i == W) || (size_i == WU);

    // word operands widened by sign, keeps both signed and unsigned order
    assign op_a = is_word ? {{32{old_v.w[0][31]}}, old_v.w[0]} : old_v.d[0];
    assign op_b = is_word ? {{32{core_v.w[0][31]}}, core_v.w[0]} : core_v.d[0];

    always_comb begin
        case (cmd_i)
            AMOADD:  amo_val = op_a + op_b;
            AMOXOR:  amo_val = op_a ^ op_b;
            AMOAND:  amo_val = op_a & op_b;
            AMOOR:   amo_val = op_a | op_b;
            AMOMIN:  amo_val = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
            AMOMAX:  amo_val = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
            AMOMINU: amo_val = (op_a < op_b) ? op_a : op_b;
            AMOMAXU: amo_val = (op_a > op_b) ? op_a : op_b;
            default: amo_val = op_b;  // swap
        endcase
    end

    // store, sc and swap write the core data unchanged
    always_comb begin
        res_v = core_v;
        if (cmd_i inside {AMOADD, AMOXOR, AMOAND, AMOOR,
                          AMOMIN, AMOMAX, AMOMINU, AMOMAXU}) begin
            res_v.d[1] = '0;
            res_v.d[0] = amo_val;  // only the low bytes get merged
        end
    end

    assign result_o = res_v.flat;

endmodule

`default_nettype wire

/* source/dmem_load_align.sv */
`default_nettype none

module dmem_load_align (
    input  dmem_pkg::line_u     line_i,
    input  logic [3:0]          offset_i,
    input  dmem_pkg::mem_size_e size_i,
    output dmem_pkg::line_u     elem_o
);
    import dmem_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;
    logic [63:0] lane_d;

    // lane select, low offset bits are zero for aligned accesses
    assign lane_b = line_i.b[offset_i];
    assign lane_h = line_i.h[offset_i[3:1]];
    assign lane_w = line_i.w[offset_i[3:2]];
    assign lane_d = line_i.d[offset_i[3]];

    always_comb begin
        case (size_i)
            B: begin
                elem_o.flat = {{120{lane_b[7]}}, lane_b};
            end
            H: begin
                elem_o.flat = {{112{lane_h[15]}}, lane_h};
            end
            W: begin
                elem_o.flat = {{96{lane_w[31]}}, lane_w};
            end
            D: begin
                elem_o.flat = {{64{lane_d[63]}}, lane_d};
            end
            BU:      elem_o.flat = {120'b0, lane_b};
            HU:      elem_o.flat = {112'b0, lane_h};
            WU:      elem_o.flat = {96'b0, lane_w};
            DU:      elem_o.flat = {64'b0, lane_d};
            default: elem_o.flat = line_i.flat;  // full line
        endcase
    end

endmodule

`default_nettype wire

/* source/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

    typedef logic [31:0] addr_t;  // byte address

    // request commands, same encoding as the core's load/store port
    typedef enum logic [4:0] {
        LOAD    = 5'd0,
        STORE   = 5'd1,
        AMOSWAP = 5'd4,
        LR      = 5'd6,
        SC      = 5'd7,
        AMOADD  = 5'd8,
        AMOXOR  = 5'd9,
        AMOOR   = 5'd10,
        AMOAND  = 5'd11,
        AMOMIN  = 5'd12,
        AMOMAX  = 5'd13,
        AMOMINU = 5'd14,
        AMOMAXU = 5'd15
    } mem_cmd_e;

    // access size, bit 2 selects zero extension
    typedef enum logic [3:0] {
        B    = 4'd0,
        H    = 4'd1,
        W    = 4'd2,
        D    = 4'd3,
        BU   = 4'd4,
        HU   = 4'd5,
        WU   = 4'd6,
        DU   = 4'd7,
        LINE = 4'd8   // whole 128-bit line
    } mem_size_e;

    // one memory line, seen flat or as naturally aligned lanes
    typedef union packed {
        logic [127:0]     flat;
        logic [15:0][7:0] b;
        logic [7:0][15:0] h;
        logic [3:0][31:0] w;
        logic [1:0][63:0] d;
    } line_u;

endpackage

`default_nettype wire

/* include/dmem_cfg.svh */
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// number of 128-bit lines in the storage array
// line index is addr[31:4] modulo this value
`define DMEM_LINES 256

// cycles from acceptance to the response pulse
// at least 2, the store data arrives one cycle after acceptance
`define DMEM_DELAY 3

`endif
